// File: verilog/core_pkg.sv
// Core word and index types, opcodes, exception causes, instruction fields and pipeline structs
package core_pkg;

	typedef logic [31:0] word_t;    // Data word and program counter
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  hf_tag_t;  // Enough for a history depth of 16

	typedef enum logic [3:0] {
		OP_LI  = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_MUL = 4'd3
	} op_e;

	typedef enum logic [1:0] {
		EXC_NONE     = 2'd0,
		EXC_ILLEGAL  = 2'd1,
		EXC_OVERFLOW = 2'd2
	} exc_e;

	// Instruction word layout
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 28;
	localparam int RD_MSB  = 27;
	localparam int RD_LSB  = 23;
	localparam int RS1_MSB = 22;
	localparam int RS1_LSB = 18;
	localparam int RS2_MSB = 17;
	localparam int RS2_LSB = 13;
	localparam int IMM_MSB = 15;  // Overlaps rs2, only LI reads it
	localparam int IMM_LSB = 0;

	typedef struct packed {
		op_e      op;
		logic     illegal;
		reg_idx_t rd;
		logic     has_rd;
		word_t    src1;
		word_t    src2;
		word_t    imm;      // Sign extended
		hf_tag_t  tag;
	} uop_t;

	typedef struct packed {
		logic     valid;
		hf_tag_t  tag;
		reg_idx_t rd;
		logic     has_rd;
		word_t    result;
		exc_e     cause;
	} wb_t;

	typedef struct packed {
		word_t    pc;
		reg_idx_t rd;
		logic     has_rd;
		word_t    old_val;  // Destination value before this instruction
	} hf_alloc_t;

endpackage

// File: verilog/issue_decode.sv
// Instruction decode with register scoreboard, hazard stall and micro-op issue
`timescale 1ns/1ns

module issue_decode (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                instr_valid_i,
	input  core_pkg::word_t     instr_i,
	input  core_pkg::word_t     pc_i,
	output logic                instr_ready_o,
	output core_pkg::reg_idx_t  rs1_idx_o,
	output core_pkg::reg_idx_t  rs2_idx_o,
	output core_pkg::reg_idx_t  rd_idx_o,
	input  core_pkg::word_t     rs1_val_i,
	input  core_pkg::word_t     rs2_val_i,
	input  core_pkg::word_t     old_val_i,
	input  core_pkg::hf_tag_t   hf_tag_i,
	input  logic                hf_full_i,
	input  logic                recovering_i,
	input  logic                kill_i,
	input  core_pkg::wb_t       alu_wb_i,
	input  core_pkg::wb_t       mul_wb_i,
	output logic                issue_o,
	output core_pkg::uop_t      uop_o,
	output core_pkg::hf_alloc_t alloc_o
);
	import core_pkg::*;

	logic [31:0] pending_q;    // One bit per register with a result in flight
	logic [31:0] pending_nxt;
	op_e         op;
	logic        illegal;
	logic        uses_rs;
	logic        has_rd;
	logic        hazard;
	word_t       imm_ext;

	assign op        = op_e'(instr_i[OPC_MSB:OPC_LSB]);
	assign rd_idx_o  = instr_i[RD_MSB:RD_LSB];
	assign rs1_idx_o = instr_i[RS1_MSB:RS1_LSB];
	assign rs2_idx_o = instr_i[RS2_MSB:RS2_LSB];
	assign imm_ext   = {{16{instr_i[IMM_MSB]}}, instr_i[IMM_MSB:IMM_LSB]};

	assign illegal = !(op inside {OP_LI, OP_ADD, OP_SUB, OP_MUL});
	assign uses_rs = op inside {OP_ADD, OP_SUB, OP_MUL};
	assign has_rd  = !illegal;  // Illegal words only carry their cause

	// RAW on the sources, WAW on the destination
	assign hazard = (uses_rs && (pending_q[rs1_idx_o] || pending_q[rs2_idx_o]))
	             || (has_rd && pending_q[rd_idx_o]);

	assign instr_ready_o = !hazard && !hf_full_i && !recovering_i;
	assign issue_o       = instr_valid_i && instr_ready_o;

	assign uop_o = '{op: op, illegal: illegal, rd: rd_idx_o, has_rd: has_rd,
	                 src1: rs1_val_i, src2: rs2_val_i, imm: imm_ext, tag: hf_tag_i};
	assign alloc_o = '{pc: pc_i, rd: rd_idx_o, has_rd: has_rd, old_val: old_val_i};

	always_comb begin
		pending_nxt = pending_q;
		if (alu_wb_i.valid && alu_wb_i.has_rd) begin
			pending_nxt[alu_wb_i.rd] = 1'b0;
		end
		if (mul_wb_i.valid && mul_wb_i.has_rd) begin
			pending_nxt[mul_wb_i.rd] = 1'b0;
		end
		if (issue_o && has_rd) begin
			pending_nxt[rd_idx_o] = 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pending_q <= '0;
		end else if (kill_i) begin
			pending_q <= '0;  // Lanes are flushed, nothing is in flight
		end else begin
			pending_q <= pending_nxt;
		end
	end

endmodule

// File: verilog/reg_file.sv
// 32-entry register file with operand, old-value and debug reads and three write ports
`timescale 1ns/1ns

module reg_file (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  core_pkg::reg_idx_t rs1_idx_i,
	input  core_pkg::reg_idx_t rs2_idx_i,
	input  core_pkg::reg_idx_t rd_idx_i,
	input  core_pkg::reg_idx_t dbg_idx_i,
	output core_pkg::word_t    rs1_val_o,
	output core_pkg::word_t    rs2_val_o,
	output core_pkg::word_t    old_val_o,
	output core_pkg::word_t    dbg_val_o,
	input  core_pkg::wb_t      alu_wb_i,
	input  core_pkg::wb_t      mul_wb_i,
	input  logic               rb_we_i,
	input  core_pkg::reg_idx_t rb_idx_i,
	input  core_pkg::word_t    rb_val_i
);
	import core_pkg::*;

	word_t regs_q [32];

	// A completion only updates state when it raised no exception
	function automatic logic wb_we(wb_t wb);
		return wb.valid && wb.has_rd && (wb.cause == EXC_NONE);
	endfunction

	assign rs1_val_o = regs_q[rs1_idx_i];
	assign rs2_val_o = regs_q[rs2_idx_i];
	assign old_val_o = regs_q[rd_idx_i];   // Saved into the history entry at issue
	assign dbg_val_o = regs_q[dbg_idx_i];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else begin
			if (wb_we(alu_wb_i)) begin
				regs_q[alu_wb_i.rd] <= alu_wb_i.result;
			end
			if (wb_we(mul_wb_i)) begin
				regs_q[mul_wb_i.rd] <= mul_wb_i.result;
			end
			if (rb_we_i) begin
				regs_q[rb_idx_i] <= rb_val_i;  // Rollback, lanes are idle here
			end
		end
	end

endmodule

// File: verilog/exec_lanes.sv
// Single-cycle ALU lane and three-stage multiply lane with completion structs and kill
`timescale 1ns/1ns

module exec_lanes (
	input  logic           clk_i,
	input  logic           arst_n_i,
	input  logic           issue_i,
	input  logic           kill_i,
	input  core_pkg::uop_t uop_i,
	output core_pkg::wb_t  alu_wb_o,
	output core_pkg::wb_t  mul_wb_o
);
	import core_pkg::*;

	logic       is_mul;
	word_t      alu_res;
	logic       alu_ovf;
	exc_e       alu_cause;
	logic       alu_vld_q;
	wb_t        alu_q;
	logic [2:0] mul_vld_q;   // Bit n is stage n+1
	word_t      mul_a_q;
	word_t      mul_b_q;
	wb_t        mul_s1_q;
	wb_t        mul_s2_q;
	wb_t        mul_s3_q;

	// Illegal words go down the ALU lane to report their cause
	assign is_mul = (uop_i.op == OP_MUL) && !uop_i.illegal;

	always_comb begin
		alu_res = '0;
		alu_ovf = 1'b0;
		case (uop_i.op)
			OP_LI: alu_res = uop_i.imm;
			OP_ADD: begin
				alu_res = uop_i.src1 + uop_i.src2;
				alu_ovf = (uop_i.src1[31] == uop_i.src2[31]) && (alu_res[31] != uop_i.src1[31]);
			end
			OP_SUB: begin
				alu_res = uop_i.src1 - uop_i.src2;
				alu_ovf = (uop_i.src1[31] != uop_i.src2[31]) && (alu_res[31] != uop_i.src1[31]);
			end
			default: alu_res = '0;
		endcase
		if (uop_i.illegal) begin
			alu_cause = EXC_ILLEGAL;
		end else if (alu_ovf) begin
			alu_cause = EXC_OVERFLOW;
		end else begin
			alu_cause = EXC_NONE;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			alu_vld_q <= 1'b0;
			mul_vld_q <= '0;
		end else if (kill_i) begin
			alu_vld_q <= 1'b0;
			mul_vld_q <= '0;
		end else begin
			alu_vld_q <= issue_i && !is_mul;
			mul_vld_q <= {mul_vld_q[1:0], issue_i && is_mul};
		end
	end

	// Payload stages, qualified by the valid bits above
	always_ff @(posedge clk_i) begin
		alu_q <= '{valid: 1'b1, tag: uop_i.tag, rd: uop_i.rd, has_rd: uop_i.has_rd,
		           result: alu_res, cause: alu_cause};
		mul_a_q  <= uop_i.src1;
		mul_b_q  <= uop_i.src2;
		mul_s1_q <= '{valid: 1'b1, tag: uop_i.tag, rd: uop_i.rd, has_rd: uop_i.has_rd,
		              result: '0, cause: EXC_NONE};
		mul_s2_q        <= mul_s1_q;
		mul_s2_q.result <= mul_a_q * mul_b_q;  // Low 32 bits only
		mul_s3_q        <= mul_s2_q;
	end

	always_comb begin
		alu_wb_o       = alu_q;
		alu_wb_o.valid = alu_vld_q;
		mul_wb_o       = mul_s3_q;
		mul_wb_o.valid = mul_vld_q[2];
	end

endmodule

// File: verilog/history_file.sv
// Circular history buffer with in-order retirement, exception report and rollback walk
`timescale 1ns/1ns

module history_file #(
	parameter int HF_DEPTH = 8
) (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                alloc_valid_i,
	input  core_pkg::hf_alloc_t alloc_i,
	output core_pkg::hf_tag_t   tag_o,
	output logic                full_o,
	output logic                recovering_o,
	output logic                kill_o,
	input  core_pkg::wb_t       alu_wb_i,
	input  core_pkg::wb_t       mul_wb_i,
	output logic                rb_we_o,
	output core_pkg::reg_idx_t  rb_idx_o,
	output core_pkg::word_t     rb_val_o,
	output logic                exc_valid_o,
	output core_pkg::word_t     exc_pc_o,
	output core_pkg::exc_e      exc_cause_o
);
	import core_pkg::*;

	localparam int PTR_W = $clog2(HF_DEPTH);

	typedef enum logic [1:0] {
		RUN,
		REPORT,
		WALK
	} hf_state_e;

	hf_state_e           state_q;
	logic [PTR_W-1:0]    head_q;
	logic [PTR_W-1:0]    tail_q;
	logic [PTR_W-1:0]    walk_q;    // Entry undone this cycle
	logic [PTR_W:0]      count_q;
	logic [HF_DEPTH-1:0] fin_q;
	hf_alloc_t           ent_q [HF_DEPTH];
	exc_e                cause_q [HF_DEPTH];
	logic [PTR_W:0]      n_ret;
	logic [PTR_W-1:0]    stop_idx;
	logic                exc_next;
	logic                flush;

	function automatic logic wb_exc(wb_t wb, logic [PTR_W-1:0] idx);
		return wb.valid && (wb.tag[PTR_W-1:0] == idx) && (wb.cause != EXC_NONE);
	endfunction

	// Count the finished, clean run at the head and look at the entry behind it
	always_comb begin
		logic             run;
		logic [PTR_W-1:0] idx;
		run   = 1'b1;
		n_ret = '0;
		for (int i = 0; i < HF_DEPTH; i++) begin
			idx = head_q + PTR_W'(i);
			if (run && ((PTR_W+1)'(i) < count_q) && fin_q[idx] && (cause_q[idx] == EXC_NONE)) begin
				n_ret = n_ret + 1'b1;
			end else begin
				run = 1'b0;
			end
		end
		stop_idx = head_q + n_ret[PTR_W-1:0];
		// Entry that becomes the head next cycle carries an exception
		exc_next = (state_q == RUN) && (n_ret < count_q)
		        && ((fin_q[stop_idx] && (cause_q[stop_idx] != EXC_NONE))
		            || wb_exc(alu_wb_i, stop_idx) || wb_exc(mul_wb_i, stop_idx));
	end

	// Walk ends at the entry just above the head
	assign flush = ((state_q == REPORT) && (count_q == (PTR_W+1)'(1)))
	            || ((state_q == WALK) && (walk_q == head_q + 1'b1));

	assign tag_o        = hf_tag_t'(tail_q);
	assign full_o       = count_q == (PTR_W+1)'(HF_DEPTH);
	assign recovering_o = state_q != RUN;
	assign kill_o       = state_q == REPORT;
	assign exc_valid_o  = state_q == REPORT;
	assign exc_pc_o     = ent_q[head_q].pc;
	assign exc_cause_o  = cause_q[head_q];
	assign rb_we_o      = (state_q == WALK) && ent_q[walk_q].has_rd;
	assign rb_idx_o     = ent_q[walk_q].rd;
	assign rb_val_o     = ent_q[walk_q].old_val;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= RUN;
			head_q  <= '0;
			tail_q  <= '0;
			walk_q  <= '0;
			count_q <= '0;
			fin_q   <= '0;
		end else begin
			if (alu_wb_i.valid) begin
				fin_q[alu_wb_i.tag[PTR_W-1:0]] <= 1'b1;
			end
			if (mul_wb_i.valid) begin
				fin_q[mul_wb_i.tag[PTR_W-1:0]] <= 1'b1;
			end
			if (alloc_valid_i) begin
				fin_q[tail_q] <= 1'b0;
				tail_q        <= tail_q + 1'b1;
			end
			case (state_q)
				RUN: begin
					head_q  <= head_q + n_ret[PTR_W-1:0];
					count_q <= count_q - n_ret + (PTR_W+1)'(alloc_valid_i);
					if (exc_next) begin
						state_q <= REPORT;
					end
				end
				REPORT: begin
					walk_q  <= tail_q - 1'b1;  // Start from the newest entry
					state_q <= WALK;
				end
				WALK: walk_q <= walk_q - 1'b1;
				default: state_q <= RUN;
			endcase
			if (flush) begin
				state_q <= RUN;
				head_q  <= tail_q;
				count_q <= '0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (alloc_valid_i) begin
			ent_q[tail_q] <= alloc_i;
		end
		if (alu_wb_i.valid) begin
			cause_q[alu_wb_i.tag[PTR_W-1:0]] <= alu_wb_i.cause;
		end
		if (mul_wb_i.valid) begin
			cause_q[mul_wb_i.tag[PTR_W-1:0]] <= mul_wb_i.cause;
		end
	end

endmodule

// File: verilog/precise_exc_core.sv
// Top level of the execution core with program counter, decode, lanes, register and history files
`timescale 1ns/1ns

module precise_exc_core #(
	parameter int HF_DEPTH = 8
) (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  logic               instr_valid_i,
	input  core_pkg::word_t    instr_i,
	output logic               instr_ready_o,
	input  core_pkg::reg_idx_t dbg_idx_i,
	output core_pkg::word_t    dbg_val_o,
	output logic               exc_valid_o,
	output core_pkg::word_t    exc_pc_o,
	output core_pkg::exc_e     exc_cause_o
);
	import core_pkg::*;

	word_t     pc_q;        // Never rewinds, squashed work keeps its number
	reg_idx_t  rs1_idx, rs2_idx, rd_idx;
	word_t     rs1_val, rs2_val, old_val;
	hf_tag_t   hf_tag;
	logic      hf_full;
	logic      recovering;
	logic      kill;
	logic      issue;
	uop_t      uop;
	hf_alloc_t alloc;
	wb_t       alu_wb, mul_wb;
	logic      rb_we;
	reg_idx_t  rb_idx;
	word_t     rb_val;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= '0;
		end else if (issue) begin
			pc_q <= pc_q + 1'b1;
		end
	end

	issue_decode u_issue_decode (
		.clk_i, .arst_n_i, .instr_valid_i, .instr_i, .pc_i(pc_q), .instr_ready_o,
		.rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx), .rd_idx_o(rd_idx),
		.rs1_val_i(rs1_val), .rs2_val_i(rs2_val), .old_val_i(old_val),
		.hf_tag_i(hf_tag), .hf_full_i(hf_full), .recovering_i(recovering), .kill_i(kill),
		.alu_wb_i(alu_wb), .mul_wb_i(mul_wb), .issue_o(issue), .uop_o(uop), .alloc_o(alloc)
	);

	reg_file u_reg_file (
		.clk_i, .arst_n_i, .rs1_idx_i(rs1_idx), .rs2_idx_i(rs2_idx), .rd_idx_i(rd_idx),
		.dbg_idx_i, .rs1_val_o(rs1_val), .rs2_val_o(rs2_val), .old_val_o(old_val), .dbg_val_o,
		.alu_wb_i(alu_wb), .mul_wb_i(mul_wb), .rb_we_i(rb_we), .rb_idx_i(rb_idx), .rb_val_i(rb_val)
	);

	exec_lanes u_exec_lanes (
		.clk_i, .arst_n_i, .issue_i(issue), .kill_i(kill), .uop_i(uop),
		.alu_wb_o(alu_wb), .mul_wb_o(mul_wb)
	);

	history_file #(.HF_DEPTH(HF_DEPTH)) u_history_file (
		.clk_i, .arst_n_i, .alloc_valid_i(issue), .alloc_i(alloc), .tag_o(hf_tag),
		.full_o(hf_full), .recovering_o(recovering), .kill_o(kill),
		.alu_wb_i(alu_wb), .mul_wb_i(mul_wb), .rb_we_o(rb_we), .rb_idx_o(rb_idx),
		.rb_val_o(rb_val), .exc_valid_o, .exc_pc_o, .exc_cause_o
	);

endmodule

// File: tests/tb_precise_exc_core.sv
// Testbench for the execution core with clock, reference model, stimulus, checks and timeout
`timescale 1ns/1ns

module tb_precise_exc_core;
	import core_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int N_DIRECTED  = 23;
	localparam int N_RANDOM    = 200;
	localparam int CYCLE_LIMIT = 40 * (N_DIRECTED + N_RANDOM) + 200;

	logic     clk_i;
	logic     arst_n_i;
	logic     instr_valid_i;
	word_t    instr_i;
	logic     instr_ready_o;
	reg_idx_t dbg_idx_i;
	word_t    dbg_val_o;
	logic     exc_valid_o;
	word_t    exc_pc_o;
	exc_e     exc_cause_o;

	// Reference model, applied in program order at acceptance
	word_t       model_regs [32] = '{default: '0};
	word_t       model_pc     = '0;
	logic        squashing    = 1'b0;  // Fault accepted, report not seen yet
	word_t       exp_pc       = '0;
	exc_e        exp_cause    = EXC_NONE;
	int          n_young      = 0;     // Accepted behind the fault
	int          walk_left    = 0;     // Rollback cycles still expected
	int          cycle_cnt    = 0;
	int          last_mul_cyc = -100;
	int          min_exc_cyc  = 0;
	int unsigned lcg_state    = 32'hdabd;
	string       test_name    = "reset_state";

	precise_exc_core #(.HF_DEPTH(8)) u_precise_exc_core (
		.clk_i, .arst_n_i, .instr_valid_i, .instr_i, .instr_ready_o,
		.dbg_idx_i, .dbg_val_o, .exc_valid_o, .exc_pc_o, .exc_cause_o
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string test, input word_t exp, input word_t act);
		assert (act === exp) else fail_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h",
		                                             test, exp, act));
	endtask

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16;  // Upper bits have the longer period
	endfunction

	function automatic word_t enc_rr(input op_e op, input int rd, input int rs1, input int rs2);
		return {op, reg_idx_t'(rd), reg_idx_t'(rs1), reg_idx_t'(rs2), 13'd0};
	endfunction

	function automatic word_t enc_li(input int rd, input logic [15:0] imm);
		return {OP_LI, reg_idx_t'(rd), 7'd0, imm};
	endfunction

	function automatic word_t enc_illegal(input logic [3:0] opc, input int rd);
		return {opc, reg_idx_t'(rd), 23'd0};
	endfunction

	function automatic word_t random_instr();
		int unsigned sel;
		int          rd;
		int          rs1;
		int          rs2;
		sel = lcg_next() % 16;
		rd  = int'(lcg_next() % 8);  // Small register pool keeps hazards frequent
		rs1 = int'(lcg_next() % 8);
		rs2 = int'(lcg_next() % 8);
		if (sel < 5) begin
			return enc_li(rd, 16'(lcg_next()));
		end else if (sel < 9) begin
			return enc_rr(OP_ADD, rd, rs1, rs2);
		end else if (sel < 12) begin
			return enc_rr(OP_SUB, rd, rs1, rs2);
		end else if (sel < 15) begin
			return enc_rr(OP_MUL, rd, rs1, rs2);
		end
		return enc_illegal(4'd4 + 4'(lcg_next() % 12), rd);
	endfunction

	// Architectural effect of one instruction on the model registers
	function automatic exc_e ref_exec(input word_t w, output word_t res);
		logic [3:0]  op;
		logic [32:0] wide;
		word_t       a;
		word_t       b;
		exc_e        cause;
		op    = w[OPC_MSB:OPC_LSB];
		a     = model_regs[w[RS1_MSB:RS1_LSB]];
		b     = model_regs[w[RS2_MSB:RS2_LSB]];
		res   = '0;
		cause = EXC_NONE;
		case (op)
			OP_LI: res = {{16{w[IMM_MSB]}}, w[IMM_MSB:IMM_LSB]};
			OP_ADD, OP_SUB: begin
				wide = (op == OP_ADD) ? {a[31], a} + {b[31], b} : {a[31], a} - {b[31], b};
				res  = wide[31:0];
				if (wide[32] != wide[31]) begin  // Guard bit and sign disagree
					cause = EXC_OVERFLOW;
				end
			end
			OP_MUL: res = a * b;
			default: cause = EXC_ILLEGAL;
		endcase
		return cause;
	endfunction

	// Faulting and squashed instructions leave the model registers untouched
	task automatic accept_instr(input word_t w);
		word_t res;
		exc_e  cause;
		if (squashing) begin
			n_young++;
		end else begin
			cause = ref_exec(w, res);
			if (cause != EXC_NONE) begin
				squashing   = 1'b1;
				exp_pc      = model_pc;
				exp_cause   = cause;
				n_young     = 0;
				min_exc_cyc = (last_mul_cyc + 5 > cycle_cnt + 2) ? last_mul_cyc + 5 : cycle_cnt + 2;
			end else begin
				model_regs[w[RD_MSB:RD_LSB]] = res;
				if (w[OPC_MSB:OPC_LSB] == OP_MUL) begin
					last_mul_cyc = cycle_cnt;  // Writes back 3 cycles later
				end
			end
		end
		model_pc++;
	endtask

	always @(posedge clk_i) begin
		if (arst_n_i) begin
			cycle_cnt++;
			if (cycle_cnt > CYCLE_LIMIT) begin
				fail_run($sformatf("Run exceeded the cycle limit of %0d cycles", CYCLE_LIMIT));
			end
			if (walk_left > 0) begin
				assert (!instr_ready_o) else fail_run("Ready rose during the rollback walk");
				walk_left--;
			end
			if (exc_valid_o) begin
				assert (squashing) else fail_run("Exception reported with no fault in flight");
				check_value(test_name, exp_pc, exc_pc_o);
				check_value(test_name, word_t'(exp_cause), word_t'(exc_cause_o));
				assert (cycle_cnt >= min_exc_cyc)
					else fail_run("Exception reported before older instructions retired");
				squashing = 1'b0;
				walk_left = n_young;  // One cycle per younger entry
			end
			if (instr_valid_i && instr_ready_o) begin
				accept_instr(instr_i);
			end
		end
	end

	assert property (@(posedge clk_i) disable iff (!arst_n_i) exc_valid_o |-> !instr_ready_o)
		else fail_run("Ready was high while an exception was reported");
	assert property (@(posedge clk_i) disable iff (!arst_n_i) exc_valid_o |=> !exc_valid_o)
		else fail_run("Exception stayed valid for more than one cycle");

	task automatic send_instr(input word_t w);
		instr_valid_i = 1'b1;
		instr_i       = w;
		@(posedge clk_i);
		while (!instr_ready_o) @(posedge clk_i);
		@(negedge clk_i);
		instr_valid_i = 1'b0;
	endtask

	// Probe word reads ready low while the register is pending or recovery runs
	task automatic check_regs(input string test);
		for (int r = 0; r < 32; r++) begin
			dbg_idx_i = reg_idx_t'(r);
			instr_i   = enc_rr(OP_ADD, r, r, r);
			@(negedge clk_i);
			while (!instr_ready_o || squashing) @(negedge clk_i);
			check_value(test, model_regs[r], dbg_val_o);
		end
	endtask

	initial begin
		arst_n_i      = 1'b0;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		dbg_idx_i     = '0;
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		arst_n_i = 1'b1;
		assert (instr_ready_o && !exc_valid_o)
			else fail_run("Ready low or exception valid right after reset");
		check_regs("reset_state");

		test_name = "mixed_ops";
		send_instr(enc_li(1, 16'd7));
		send_instr(enc_li(2, 16'hfffd));
		send_instr(enc_rr(OP_MUL, 3, 1, 2));  // Finishes after the younger ones
		send_instr(enc_li(4, 16'd100));
		send_instr(enc_rr(OP_ADD, 5, 1, 4));
		send_instr(enc_rr(OP_SUB, 6, 4, 2));
		send_instr(enc_rr(OP_ADD, 7, 3, 5));
		check_regs(test_name);

		test_name = "add_overflow";
		send_instr(enc_li(8, 16'h4000));
		send_instr(enc_li(9, 16'd4));
		send_instr(enc_rr(OP_MUL, 10, 8, 8));
		send_instr(enc_rr(OP_MUL, 11, 10, 9));   // 0x4000_0000
		send_instr(enc_rr(OP_ADD, 12, 11, 11));  // Overflows
		send_instr(enc_li(1, 16'd55));           // Younger, must be undone
		send_instr(enc_rr(OP_SUB, 13, 4, 2));
		send_instr(enc_li(12, 16'd9));
		check_regs(test_name);

		test_name = "sub_overflow";
		send_instr(enc_li(20, 16'd2));
		send_instr(enc_rr(OP_MUL, 18, 11, 20));  // 0x8000_0000
		send_instr(enc_rr(OP_SUB, 19, 18, 20));
		send_instr(enc_li(24, 16'h1234));
		check_regs(test_name);

		test_name = "illegal_behind_mul";
		send_instr(enc_rr(OP_MUL, 21, 1, 4));
		send_instr(enc_illegal(4'hc, 22));
		send_instr(enc_li(21, 16'd5));  // WAW stall, then squashed
		send_instr(enc_li(23, 16'd77));
		check_regs(test_name);

		test_name = "random_stream";
		for (int i = 0; i < N_RANDOM; i++) begin
			repeat (lcg_next() % 3) @(negedge clk_i);
			send_instr(random_instr());
		end
		check_regs(test_name);

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: precise_exc_core.f
verilog/core_pkg.sv
verilog/issue_decode.sv
verilog/reg_file.sv
verilog/exec_lanes.sv
verilog/history_file.sv
verilog/precise_exc_core.sv
tests/tb_precise_exc_core.sv
